// File: src/adc_cfg_pkg.sv
/*
 * Build-time constants for the 8-bit dual-channel ADC receive path.
 * The sizes are fixed by the frame layout. frame_w must stay equal to
 * the width of frame_t in adc_frame_pkg.
 * The FIFO pointers wrap on their own, so fifo_depth must be 2**fifo_aw.
 */

package adc_cfg_pkg;

  // ------------------------------------------------------------
  // sample and frame geometry
  // ------------------------------------------------------------
  localparam int sample_w = 8;  // bits per adc sample
  localparam int n_lanes  = 4;  // di_d, di, dq_d, dq
  localparam int n_slots  = 4;  // samples per lane gathered per frame

  // 128 data bits + early/late overrange + one sync bit per slot
  localparam int frame_w = n_lanes * n_slots * sample_w + 2 + n_slots;

  // frame buffer
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = 2;  // log2(fifo_depth)

  // capture stage: second input register on by default
  localparam bit extra_reg_default = 1'b1;

endpackage

// File: src/adc_frame_pkg.sv
/*
 * Frame types. One 134-bit frame word is seen two ways: the lane view
 * that the deserializer fills, and the user view that the top level
 * splits onto its output bytes. Both structs must cover the same bits.
 * Within a lane slot 0 sits in the top byte and slot 3 (newest) in the
 * low byte, which gives the user byte order of the port table.
 */

package adc_frame_pkg;
  import adc_cfg_pkg::*;

  typedef logic [sample_w-1:0] sample_t;  // one adc sample

  // index = slot number, ascending range puts slot 3 in the low byte
  typedef sample_t [0:n_slots-1] lane_slots_t;

  // ------------------------------------------------------------
  // lane view, written by the deserializer
  // ------------------------------------------------------------
  typedef struct packed {
    logic [n_slots-1:0] sync;       // bit k = sync level in slot k
    logic               ovr_late;   // or of slots 2..3
    logic               ovr_early;  // or of slots 0..1
    lane_slots_t        dq;         // bits 127:96
    lane_slots_t        dq_d;       // bits 95:64
    lane_slots_t        di;         // bits 63:32
    lane_slots_t        di_d;       // bits 31:0
  } frame_lanes_t;

  // ------------------------------------------------------------
  // user view, msb first, same bits as above
  // ------------------------------------------------------------
  typedef struct packed {
    logic    sync3;
    logic    sync2;
    logic    sync1;
    logic    sync0;
    logic    outofrange1;  // = ovr_late
    logic    outofrange0;  // = ovr_early
    sample_t q31;          // dq slot 0
    sample_t q30;
    sample_t q11;
    sample_t q10;          // dq slot 3
    sample_t i31;          // dq_d slot 0
    sample_t i30;
    sample_t i11;
    sample_t i10;          // dq_d slot 3
    sample_t q21;          // di slot 0
    sample_t q20;
    sample_t q01;
    sample_t q00;          // di slot 3
    sample_t i21;          // di_d slot 0
    sample_t i20;
    sample_t i01;
    sample_t i00;          // di_d slot 3, frame bits 7:0
  } frame_user_t;

  typedef union packed {
    frame_lanes_t lanes;
    frame_user_t  user;
  } frame_t;

endpackage

// File: src/adc_lane_if.sv
/*
 * One captured sample set, passed from the input stage to the
 * deserializer. valid is a level: low in reset, high from the first
 * captured sample on. There is no back-pressure.
 */

interface adc_lane_if
  import adc_frame_pkg::*;
();

  sample_t di_d;       // i channel, delayed bus
  sample_t di;         // i channel
  sample_t dq_d;       // q channel, delayed bus
  sample_t dq;         // q channel
  logic    sync;       // sync level for this sample
  logic    overrange;  // overrange level for this sample
  logic    valid;      // stream running

  modport capture (
    output di_d, di, dq_d, dq, sync, overrange, valid
  );

  modport deser (
    input  di_d, di, dq_d, dq, sync, overrange, valid
  );

endinterface

// File: src/adc_input_capture.sv
/*
 * Input register stage for the four adc lanes plus sync and overrange.
 * The first adc_clk edge with dcm_reset low captures slot 0.
 * Latency to the lane interface is 1 cycle, or 2 with extra_reg set.
 * Sample payload is not reset, only the valid level is.
 */

module adc_input_capture
  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;
#(
  parameter bit extra_reg = extra_reg_default  // add a second register stage
) (
  input  logic        adc_clk,
  input  logic        dcm_reset,
  input  sample_t     di_d,
  input  sample_t     di,
  input  sample_t     dq_d,
  input  sample_t     dq,
  input  logic        sync,
  input  logic        overrange,
  adc_lane_if.capture lane
);

  // all lanes + sync + overrange as one word
  logic [n_lanes*sample_w+1:0] in_word;
  logic [n_lanes*sample_w+1:0] s1_word;
  logic [n_lanes*sample_w+1:0] out_word;
  logic                        s1_valid;
  logic                        out_valid;

  assign in_word = {di_d, di, dq_d, dq, sync, overrange};

  // ------------------------------------------------------------
  // first stage, always present
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    s1_word <= in_word;  // payload, no reset
  end

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= 1'b1;  // goes high with the first captured sample
    end
  end

  // optional second stage for timing
  generate
    if (extra_reg) begin : g_extra
      logic [n_lanes*sample_w+1:0] s2_word;
      logic                        s2_valid;

      always_ff @(posedge adc_clk) begin
        s2_word <= s1_word;
        if (dcm_reset) begin
          s2_valid <= 1'b0;
        end else begin
          s2_valid <= s1_valid;  // valid keeps step with data
        end
      end

      assign out_word  = s2_word;
      assign out_valid = s2_valid;
    end else begin : g_direct
      assign out_word  = s1_word;
      assign out_valid = s1_valid;
    end
  endgenerate

  assign {lane.di_d, lane.di, lane.dq_d, lane.dq, lane.sync, lane.overrange} = out_word;
  assign lane.valid = out_valid;

endmodule

// File: src/adc_deserializer.sv
/*
 * Gathers four consecutive sample sets into one frame.
 * The slot counter starts at 0 with the first valid sample after reset
 * and never slips, so frame alignment is fixed by reset release.
 * frame_valid pulses 1 cycle after the slot-3 sample and frame holds
 * until the next frame is built.
 */

module adc_deserializer
  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;
(
  input  logic      adc_clk,
  input  logic      dcm_reset,
  adc_lane_if.deser lane,
  output frame_t    frame,
  output logic      frame_valid
);

  logic [$clog2(n_slots)-1:0] slot_q;     // wraps 3 -> 0
  logic                       last_slot;
  sample_t     [n_lanes-1:0]  cur;        // [3]=dq ... [0]=di_d, frame order
  lane_slots_t [n_lanes-1:0]  shift_q;    // per-lane shift store
  lane_slots_t [n_lanes-1:0]  shift_d;
  logic [n_slots-2:0]         sync_q;     // bit k = slot k, slots 0..2
  logic [n_slots-2:0]         ovr_q;      // same, for overrange

  assign last_slot = (int'(slot_q) == n_slots - 1);
  assign cur       = {lane.dq, lane.dq_d, lane.di, lane.di_d};

  // new sample enters at the low end, oldest drops off the top
  always_comb begin
    for (int l = 0; l < n_lanes; l++) begin
      shift_d[l] = {shift_q[l][1:n_slots-1], cur[l]};
    end
  end

  // ------------------------------------------------------------
  // slot counter and frame strobe
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      slot_q      <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= lane.valid & last_slot;  // one pulse per 4 samples
      if (lane.valid) begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // payload stores and frame assembly
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (lane.valid) begin
      shift_q <= shift_d;
      // shift right, so after slots 0..2 bit k holds slot k
      sync_q  <= {lane.sync, sync_q[n_slots-2:1]};
      ovr_q   <= {lane.overrange, ovr_q[n_slots-2:1]};
    end

    if (lane.valid && last_slot) begin
      // slot 3 comes straight from the lane, the rest from the stores
      frame.lanes.sync      <= {lane.sync, sync_q};
      frame.lanes.ovr_early <= |ovr_q[n_slots/2-1:0];
      frame.lanes.ovr_late  <= lane.overrange | (|ovr_q[n_slots-2:n_slots/2]);
      frame.lanes.dq        <= shift_d[3];
      frame.lanes.dq_d      <= shift_d[2];
      frame.lanes.di        <= shift_d[1];
      frame.lanes.di_d      <= shift_d[0];
    end
  end

  // frames are at least n_slots cycles apart
  a_frame_spacing: assert property (
    @(posedge adc_clk) disable iff (dcm_reset)
      frame_valid |=> !frame_valid
  );

endmodule

// File: src/adc_frame_fifo.sv
/*
 * Single-clock frame FIFO on adc_clk, 4 entries of frame_w bits.
 * The read enable is the registered not-empty flag, so every stored
 * frame is popped on its own. rd_valid is high for exactly 1 cycle per
 * popped frame and rd_frame holds until the next pop.
 * No back-pressure: the writer must stay slower than the drain rate.
 */

module adc_frame_fifo
  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;
(
  input  logic   adc_clk,
  input  logic   dcm_reset,
  input  frame_t wr_frame,
  input  logic   wr_en,
  output frame_t rd_frame,
  output logic   rd_valid
);

  logic [frame_w-1:0] mem [fifo_depth];  // register array, no reset
  logic [fifo_aw-1:0] wr_ptr;            // wraps at fifo_depth
  logic [fifo_aw-1:0] rd_ptr;
  logic [fifo_aw:0]   count;             // entries stored
  logic [fifo_aw:0]   count_d;
  logic               empty;
  logic               full;
  logic               rd_en;             // registered not-empty

  assign empty = (wr_ptr == rd_ptr) && !full;  // pointer view of occupancy
  assign full  = (int'(count) == fifo_depth);

  // next occupancy
  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_d = count + 1'b1;
      2'b01:   count_d = count - 1'b1;
      default: count_d = count;  // idle, or write and pop together
    endcase
  end

  // ------------------------------------------------------------
  // pointers, count and read enable
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_en    <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      count    <= count_d;
      rd_en    <= (count_d != '0);  // not-empty as of the next cycle
      rd_valid <= rd_en;            // data lands in rd_frame with this
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage and output register
  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_frame;
    end
    if (rd_en) begin
      rd_frame <= mem[rd_ptr];  // held until the next pop
    end
  end

  // upstream frame rate must stay below the drain rate
  a_no_write_full: assert property (
    @(posedge adc_clk) disable iff (dcm_reset)
      wr_en |-> !full
  );

  // registered read enable must track the occupancy
  a_no_read_empty: assert property (
    @(posedge adc_clk) disable iff (dcm_reset)
      rd_en |-> !empty
  );

endmodule

// File: src/adc_serdes_rx.sv
/*
 * Receive path top: capture, 4-to-1 deserializer and frame FIFO, all on
 * adc_clk with synchronous dcm_reset. Inputs are a continuous stream,
 * one sample per lane each cycle. user_data_valid pulses once per frame
 * of 4 samples. The first cycle after reset release is slot 0.
 * The capture stage runs with its default extra input register.
 */

module adc_serdes_rx
  import adc_frame_pkg::*;
(
  input  logic    adc_clk,
  input  logic    dcm_reset,
  // adc side
  input  sample_t adc_di_d,
  input  sample_t adc_di,
  input  sample_t adc_dq_d,
  input  sample_t adc_dq,
  input  logic    adc_sync,
  input  logic    adc_overrange,
  // user side, i channel
  output sample_t user_datai00,
  output sample_t user_datai01,
  output sample_t user_datai10,
  output sample_t user_datai11,
  output sample_t user_datai20,
  output sample_t user_datai21,
  output sample_t user_datai30,
  output sample_t user_datai31,
  // user side, q channel
  output sample_t user_dataq00,
  output sample_t user_dataq01,
  output sample_t user_dataq10,
  output sample_t user_dataq11,
  output sample_t user_dataq20,
  output sample_t user_dataq21,
  output sample_t user_dataq30,
  output sample_t user_dataq31,
  // per-frame status
  output logic    user_sync0,
  output logic    user_sync1,
  output logic    user_sync2,
  output logic    user_sync3,
  output logic    user_outofrange0,
  output logic    user_outofrange1,
  output logic    user_data_valid
);

  adc_lane_if lane_bus ();  // capture -> deserializer

  frame_t frame;        // lane view written by u_deser
  logic   frame_valid;
  frame_t user_frame;   // user view read below

  // ------------------------------------------------------------
  // pipeline
  // ------------------------------------------------------------
  adc_input_capture u_capture (
    .adc_clk   (adc_clk),
    .dcm_reset (dcm_reset),
    .di_d      (adc_di_d),
    .di        (adc_di),
    .dq_d      (adc_dq_d),
    .dq        (adc_dq),
    .sync      (adc_sync),
    .overrange (adc_overrange),
    .lane      (lane_bus.capture)
  );

  adc_deserializer u_deser (
    .adc_clk     (adc_clk),
    .dcm_reset   (dcm_reset),
    .lane        (lane_bus.deser),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  adc_frame_fifo u_fifo (
    .adc_clk   (adc_clk),
    .dcm_reset (dcm_reset),
    .wr_frame  (frame),
    .wr_en     (frame_valid),
    .rd_frame  (user_frame),
    .rd_valid  (user_data_valid)
  );

  // ------------------------------------------------------------
  // user view split onto the ports
  // ------------------------------------------------------------
  assign user_datai00 = user_frame.user.i00;  // di_d slot 3
  assign user_datai01 = user_frame.user.i01;
  assign user_datai20 = user_frame.user.i20;
  assign user_datai21 = user_frame.user.i21;  // di_d slot 0
  assign user_dataq00 = user_frame.user.q00;  // di slot 3
  assign user_dataq01 = user_frame.user.q01;
  assign user_dataq20 = user_frame.user.q20;
  assign user_dataq21 = user_frame.user.q21;
  assign user_datai10 = user_frame.user.i10;  // dq_d slot 3
  assign user_datai11 = user_frame.user.i11;
  assign user_datai30 = user_frame.user.i30;
  assign user_datai31 = user_frame.user.i31;
  assign user_dataq10 = user_frame.user.q10;  // dq slot 3
  assign user_dataq11 = user_frame.user.q11;
  assign user_dataq30 = user_frame.user.q30;
  assign user_dataq31 = user_frame.user.q31;

  assign user_sync0       = user_frame.user.sync0;
  assign user_sync1       = user_frame.user.sync1;
  assign user_sync2       = user_frame.user.sync2;
  assign user_sync3       = user_frame.user.sync3;
  assign user_outofrange0 = user_frame.user.outofrange0;  // slots 0..1
  assign user_outofrange1 = user_frame.user.outofrange1;  // slots 2..3

endmodule

// File: tests/tb_adc_serdes_rx.sv
/*
 * Testbench for the adc receive path top level.
 * Assumes a continuous input stream: the first adc_clk edge after
 * dcm_reset falls captures slot 0, every 4 samples make one frame.
 * Expected frames follow the lane/slot to user byte table, sync bit k
 * from slot k, early overrange from slots 0..1 and late from slots 2..3.
 */

module tb_adc_serdes_rx;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_fixed  = 12;  // hand-written rows
  localparam int n_random = 40;  // long random run
  localparam int n_rows   = n_fixed + n_random;

  typedef enum logic [1:0] {mode_count, mode_ones, mode_rand} data_mode_e;

  typedef struct {
    logic [3:0] sync;  // bit k = sync level in slot k
    logic [3:0] ovr;   // bit k = overrange level in slot k
    data_mode_e mode;
  } row_t;

  // data index = lane * 4 + slot, lanes di_d, di, dq_d, dq
  typedef struct packed {
    logic [3:0]       sync;
    logic             early;
    logic             late;
    logic [15:0][7:0] data;
  } exp_frame_t;

  logic       adc_clk = 1'b0;
  logic       dcm_reset;
  logic [7:0] adc_di_d, adc_di, adc_dq_d, adc_dq;
  logic       adc_sync, adc_overrange;
  logic [7:0] user_datai00, user_datai01, user_datai10, user_datai11;
  logic [7:0] user_datai20, user_datai21, user_datai30, user_datai31;
  logic [7:0] user_dataq00, user_dataq01, user_dataq10, user_dataq11;
  logic [7:0] user_dataq20, user_dataq21, user_dataq30, user_dataq31;
  logic       user_sync0, user_sync1, user_sync2, user_sync3;
  logic       user_outofrange0, user_outofrange1;
  logic       user_data_valid;

  row_t       rows [n_rows];
  exp_frame_t exp_q [$];      // frames sent, not yet seen
  exp_frame_t mon_exp;
  int         frames_seen = 0;
  logic [31:0] rng_state;

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  adc_serdes_rx u_dut (
    .adc_clk          (adc_clk),
    .dcm_reset        (dcm_reset),
    .adc_di_d         (adc_di_d),
    .adc_di           (adc_di),
    .adc_dq_d         (adc_dq_d),
    .adc_dq           (adc_dq),
    .adc_sync         (adc_sync),
    .adc_overrange    (adc_overrange),
    .user_datai00     (user_datai00),
    .user_datai01     (user_datai01),
    .user_datai10     (user_datai10),
    .user_datai11     (user_datai11),
    .user_datai20     (user_datai20),
    .user_datai21     (user_datai21),
    .user_datai30     (user_datai30),
    .user_datai31     (user_datai31),
    .user_dataq00     (user_dataq00),
    .user_dataq01     (user_dataq01),
    .user_dataq10     (user_dataq10),
    .user_dataq11     (user_dataq11),
    .user_dataq20     (user_dataq20),
    .user_dataq21     (user_dataq21),
    .user_dataq30     (user_dataq30),
    .user_dataq31     (user_dataq31),
    .user_sync0       (user_sync0),
    .user_sync1       (user_sync1),
    .user_sync2       (user_sync2),
    .user_sync3       (user_sync3),
    .user_outofrange0 (user_outofrange0),
    .user_outofrange1 (user_outofrange1),
    .user_data_valid  (user_data_valid)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int idx(input int lane, input int slot);
    return lane * 4 + slot;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp_v,
                            input logic [7:0] act_v);
    assert (act_v === exp_v) else begin
      abort_run($sformatf("[FAIL] %s frame %0d: expected 0x%02h, actual 0x%02h",
                          name, frames_seen, exp_v, act_v));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    assert (act_v === exp_v) else begin
      abort_run($sformatf("[FAIL] %s frame %0d: expected 0x%0h, actual 0x%0h",
                          name, frames_seen, exp_v, act_v));
    end
  endtask

  // port table: slot 3 -> x0 byte, slot 0 -> x1 of the odd pair
  task automatic check_frame(input exp_frame_t e);
    check_byte("user_datai00", e.data[idx(0, 3)], user_datai00);  // di_d
    check_byte("user_datai01", e.data[idx(0, 2)], user_datai01);
    check_byte("user_datai20", e.data[idx(0, 1)], user_datai20);
    check_byte("user_datai21", e.data[idx(0, 0)], user_datai21);
    check_byte("user_dataq00", e.data[idx(1, 3)], user_dataq00);  // di
    check_byte("user_dataq01", e.data[idx(1, 2)], user_dataq01);
    check_byte("user_dataq20", e.data[idx(1, 1)], user_dataq20);
    check_byte("user_dataq21", e.data[idx(1, 0)], user_dataq21);
    check_byte("user_datai10", e.data[idx(2, 3)], user_datai10);  // dq_d
    check_byte("user_datai11", e.data[idx(2, 2)], user_datai11);
    check_byte("user_datai30", e.data[idx(2, 1)], user_datai30);
    check_byte("user_datai31", e.data[idx(2, 0)], user_datai31);
    check_byte("user_dataq10", e.data[idx(3, 3)], user_dataq10);  // dq
    check_byte("user_dataq11", e.data[idx(3, 2)], user_dataq11);
    check_byte("user_dataq30", e.data[idx(3, 1)], user_dataq30);
    check_byte("user_dataq31", e.data[idx(3, 0)], user_dataq31);
    check_flag("user_sync0", e.sync[0], user_sync0);
    check_flag("user_sync1", e.sync[1], user_sync1);
    check_flag("user_sync2", e.sync[2], user_sync2);
    check_flag("user_sync3", e.sync[3], user_sync3);
    check_flag("user_outofrange0", e.early, user_outofrange0);
    check_flag("user_outofrange1", e.late, user_outofrange1);
  endtask

  task automatic build_table();
    rows[0]  = '{4'b0001, 4'b0000, mode_count};  // single sync bits
    rows[1]  = '{4'b0010, 4'b0001, mode_count};  // early half only
    rows[2]  = '{4'b0100, 4'b0010, mode_count};
    rows[3]  = '{4'b1000, 4'b0100, mode_count};  // late half only
    rows[4]  = '{4'b0000, 4'b1000, mode_count};  // no sync
    rows[5]  = '{4'b1010, 4'b0011, mode_ones};
    rows[6]  = '{4'b0101, 4'b1100, mode_count};
    rows[7]  = '{4'b1111, 4'b1111, mode_ones};
    rows[8]  = '{4'b0000, 4'b0000, mode_ones};
    rows[9]  = '{4'b0110, 4'b0110, mode_count};  // one bit in each half
    rows[10] = '{4'b1001, 4'b1001, mode_rand};
    rows[11] = '{4'b0011, 4'b0000, mode_count};
    for (int i = n_fixed; i < n_rows; i++) begin
      rng_state = xorshift32(rng_state);
      rows[i]   = '{rng_state[3:0], rng_state[7:4], mode_rand};
    end
  endtask

  // ------------------------------------------------------------
  // one frame: 4 samples per lane, inputs change 5 ns after the edge
  // ------------------------------------------------------------
  task automatic drive_row(input int r);
    exp_frame_t e;
    logic [7:0] smp [4];
    for (int s = 0; s < 4; s++) begin
      for (int l = 0; l < 4; l++) begin
        case (rows[r].mode)
          mode_count: smp[l] = 8'(r * 16 + l * 4 + s);  // lane and slot in low nibble
          mode_ones:  smp[l] = 8'hff;
          default: begin
            rng_state = xorshift32(rng_state);
            smp[l]    = rng_state[7:0];
          end
        endcase
        e.data[idx(l, s)] = smp[l];
      end
      adc_di_d      = smp[0];
      adc_di        = smp[1];
      adc_dq_d      = smp[2];
      adc_dq        = smp[3];
      adc_sync      = rows[r].sync[s];
      adc_overrange = rows[r].ovr[s];
      @(posedge adc_clk);
      #5;
    end
    e.sync  = rows[r].sync;
    e.early = rows[r].ovr[0] | rows[r].ovr[1];
    e.late  = rows[r].ovr[2] | rows[r].ovr[3];
    exp_q.push_back(e);  // only now may the frame show up
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    dcm_reset     = 1'b1;
    adc_di_d      = 8'h00;
    adc_di        = 8'h00;
    adc_dq_d      = 8'h00;
    adc_dq        = 8'h00;
    adc_sync      = 1'b0;
    adc_overrange = 1'b0;
    rng_state     = 32'hda630a76;
    build_table();

    repeat (16) @(posedge adc_clk);
    #5;
    dcm_reset = 1'b0;  // next edge captures slot 0 of row 0

    for (int r = 0; r < n_rows; r++) begin
      drive_row(r);
    end

    while (frames_seen < n_rows) @(negedge adc_clk);  // watchdog bounds this
    @(posedge adc_clk);

    if (exp_q.size() == 0 && frames_seen == n_rows) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("%0d expected frames never arrived", exp_q.size()));
    end
  end

  // output monitor, mid-cycle sampling
  always @(negedge adc_clk) begin
    assert (!$isunknown(user_data_valid)) else begin
      abort_run("user_data_valid is unknown");
    end
    if (user_data_valid === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        abort_run("user_data_valid pulsed before a complete frame was sent");
      end
      mon_exp = exp_q.pop_front();
      check_frame(mon_exp);
      frames_seen++;
    end
  end

  // watchdog sized from the table length
  initial begin
    repeat (n_rows * 4 + 40) @(posedge adc_clk);
    abort_run($sformatf("timeout: only %0d of %0d frames arrived", frames_seen, n_rows));
  end

endmodule

// File: adc_serdes_rx.f
src/adc_cfg_pkg.sv
src/adc_frame_pkg.sv
src/adc_lane_if.sv
src/adc_input_capture.sv
src/adc_deserializer.sv
src/adc_frame_fifo.sv
src/adc_serdes_rx.sv
tests/tb_adc_serdes_rx.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the adc receive path testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f adc_serdes_rx.f --top-module tb_adc_serdes_rx -o sim_tb

# the log decides the result, so a stopped simulation must not end the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
